/* common/dtim_defines.svh */
`ifndef DTIM_DEFINES_SVH
`define DTIM_DEFINES_SVH

// Address and data word width.
`define DTIM_ADDR_BITS 32

// Line index bits, giving 64 lines.
`define DTIM_INDEX_BITS 6

// Tag bits above the index and the byte offset.
`define DTIM_TAG_BITS (`DTIM_ADDR_BITS - `DTIM_INDEX_BITS - 2)

// First byte address of the window.
`define DTIM_BASE_ADDR 32'h0000_1000

// First byte address past the window.
`define DTIM_TOP_ADDR 32'h0000_3000

`endif

/* common/dtim_bus_pkg.sv */
`default_nettype none

`include "dtim_defines.svh"

package dtim_bus_pkg;

  // Processor side request, valid for a single cycle.
  typedef struct packed {
    logic                           valid;
    logic [`DTIM_ADDR_BITS-1:0]     addr;
    logic [`DTIM_ADDR_BITS-1:0]     wdata;
    logic [`DTIM_ADDR_BITS/8-1:0]   wstrb; // All clear means a load.
  } dtim_req_t;

  typedef struct packed {
    logic                       ready;
    logic [`DTIM_ADDR_BITS-1:0] rdata;
  } dtim_rsp_t;

  // Backing memory request, the address is always word aligned.
  typedef struct packed {
    logic                           valid;
    logic [`DTIM_ADDR_BITS-1:0]     addr;
    logic [`DTIM_ADDR_BITS-1:0]     wdata;
    logic [`DTIM_ADDR_BITS/8-1:0]   wstrb;
  } mem_req_t;

  typedef struct packed {
    logic                       ready;
    logic [`DTIM_ADDR_BITS-1:0] rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

/* common/dtim_core_pkg.sv */
`default_nettype none

`include "dtim_defines.svh"

package dtim_core_pkg;

  typedef enum logic {
    OP_LOAD,
    OP_STORE
  } dtim_op_t;

  // One line of the array.
  typedef struct packed {
    logic                       lock; // Set once the line holds a valid word.
    logic [`DTIM_TAG_BITS-1:0]  tag;
    logic [`DTIM_ADDR_BITS-1:0] data;
  } dtim_line_t;

  // Request as held by the decode stage.
  typedef struct packed {
    logic                           valid;
    dtim_op_t                       op;
    logic [`DTIM_ADDR_BITS-1:0]     addr; // Word aligned.
    logic [`DTIM_TAG_BITS-1:0]      tag;
    logic [`DTIM_INDEX_BITS-1:0]    index;
    logic [`DTIM_ADDR_BITS-1:0]     wdata;
    logic [`DTIM_ADDR_BITS/8-1:0]   wstrb;
  } dtim_decoded_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FILL,
    ST_BYPASS
  } dtim_state_t;

  // How the current request is finished.
  typedef enum logic [1:0] {
    KIND_HIT,
    KIND_FILL,
    KIND_BYPASS
  } dtim_kind_t;

endpackage

`default_nettype wire

/* rtl/dtim_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dtim_defines.svh"

module dtim_decode (
  input  logic                         clock,
  input  logic                         reset,
  input  dtim_bus_pkg::dtim_req_t      req,
  output logic [`DTIM_INDEX_BITS-1:0]  read_index,
  output dtim_core_pkg::dtim_decoded_t decoded
);

  logic                         valid_q;
  dtim_core_pkg::dtim_decoded_t incoming;
  dtim_core_pkg::dtim_decoded_t captured;

  always_comb begin
    incoming.valid = req.valid;
    incoming.op    = (|req.wstrb) ? dtim_core_pkg::OP_STORE : dtim_core_pkg::OP_LOAD;
    incoming.addr  = {req.addr[`DTIM_ADDR_BITS-1:2], 2'b00};
    incoming.tag   = req.addr[`DTIM_ADDR_BITS-1:`DTIM_INDEX_BITS+2];
    incoming.index = req.addr[`DTIM_INDEX_BITS+1:2];
    incoming.wdata = req.wdata;
    incoming.wstrb = req.wstrb;
  end

  // Between requests the array keeps reading the held line.
  assign read_index = req.valid ? incoming.index : captured.index;

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req.valid; // High for the one cycle after capture.
    end
  end

  always_ff @(posedge clock) begin
    if (req.valid) begin
      captured <= incoming;
    end
  end

  always_comb begin
    decoded       = captured;
    decoded.valid = valid_q;
  end

endmodule

`default_nettype wire

/* rtl/dtim_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dtim_defines.svh"

module dtim_store (
  input  logic                        clock,
  input  logic [`DTIM_INDEX_BITS-1:0] read_index,
  output dtim_core_pkg::dtim_line_t   line,
  input  logic                        write_enable,
  input  logic [`DTIM_INDEX_BITS-1:0] write_index,
  input  dtim_core_pkg::dtim_line_t   write_line
);

  // Every line starts unlocked.
  dtim_core_pkg::dtim_line_t lines [0:(1 << `DTIM_INDEX_BITS)-1] = '{default: '0};

  logic [`DTIM_INDEX_BITS-1:0] read_index_q = '0;

  always_ff @(posedge clock) begin
    read_index_q <= read_index;
    if (write_enable) begin
      lines[write_index] <= write_line;
    end
  end

  assign line = lines[read_index_q];

endmodule

`default_nettype wire

/* rtl/dtim_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dtim_defines.svh"

module dtim_control (
  input  logic                         clock,
  input  logic                         reset,
  input  dtim_core_pkg::dtim_decoded_t decoded,
  input  dtim_core_pkg::dtim_line_t    line,
  output dtim_bus_pkg::mem_req_t       mem_req,
  input  logic                         mem_ready,
  output logic                         finish,
  output dtim_core_pkg::dtim_kind_t    kind
);

  dtim_core_pkg::dtim_state_t state;
  dtim_core_pkg::dtim_state_t state_next;
  dtim_core_pkg::dtim_kind_t  classified;
  logic                       in_window;

  always_comb begin
    in_window = (decoded.addr >= `DTIM_BASE_ADDR) && (decoded.addr < `DTIM_TOP_ADDR);
    if (!in_window) begin
      classified = dtim_core_pkg::KIND_BYPASS;
    end else if (!line.lock) begin
      classified = dtim_core_pkg::KIND_FILL;
    end else if (line.tag != decoded.tag) begin
      classified = dtim_core_pkg::KIND_BYPASS; // Line is held by another address.
    end else begin
      classified = dtim_core_pkg::KIND_HIT;
    end
  end

  always_comb begin
    state_next    = state;
    finish        = 1'b0;
    mem_req.valid = 1'b0;
    kind          = classified;
    case (state)
      dtim_core_pkg::ST_IDLE: begin
        if (decoded.valid) begin
          if (classified == dtim_core_pkg::KIND_HIT) begin
            finish = 1'b1;
          end else begin
            mem_req.valid = 1'b1;
            state_next = (classified == dtim_core_pkg::KIND_FILL) ?
                         dtim_core_pkg::ST_FILL : dtim_core_pkg::ST_BYPASS;
          end
        end
      end
      dtim_core_pkg::ST_FILL: begin
        kind = dtim_core_pkg::KIND_FILL;
        if (mem_ready) begin
          finish     = 1'b1;
          state_next = dtim_core_pkg::ST_IDLE;
        end
      end
      dtim_core_pkg::ST_BYPASS: begin
        kind = dtim_core_pkg::KIND_BYPASS;
        if (mem_ready) begin
          finish     = 1'b1;
          state_next = dtim_core_pkg::ST_IDLE;
        end
      end
      default: state_next = dtim_core_pkg::ST_IDLE;
    endcase
    // A fill is a plain read, and the store bytes are merged on return.
    mem_req.addr  = decoded.addr;
    mem_req.wdata = (kind == dtim_core_pkg::KIND_BYPASS) ? decoded.wdata : '0;
    mem_req.wstrb = (kind == dtim_core_pkg::KIND_BYPASS) ? decoded.wstrb : '0;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= dtim_core_pkg::ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

endmodule

`default_nettype wire

/* rtl/dtim_respond.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dtim_defines.svh"

module dtim_respond (
  input  dtim_core_pkg::dtim_decoded_t decoded,
  input  dtim_core_pkg::dtim_line_t    line,
  input  logic [`DTIM_ADDR_BITS-1:0]   mem_rdata,
  input  logic                         finish,
  input  dtim_core_pkg::dtim_kind_t    kind,
  output dtim_bus_pkg::dtim_rsp_t      rsp,
  output logic                         write_enable,
  output logic [`DTIM_INDEX_BITS-1:0]  write_index,
  output dtim_core_pkg::dtim_line_t    write_line
);

  logic [`DTIM_ADDR_BITS-1:0] base;
  logic [`DTIM_ADDR_BITS-1:0] merged;
  logic                       is_store;

  always_comb begin
    // A hit works on the stored word, the other paths on the memory word.
    base   = (kind == dtim_core_pkg::KIND_HIT) ? line.data : mem_rdata;
    merged = base;
    for (int b = 0; b < `DTIM_ADDR_BITS/8; b++) begin
      if (decoded.wstrb[b]) begin
        merged[8*b +: 8] = decoded.wdata[8*b +: 8];
      end
    end
  end

  assign is_store = (decoded.op == dtim_core_pkg::OP_STORE);

  always_comb begin
    write_enable = 1'b0;
    if (finish) begin
      write_enable = (kind == dtim_core_pkg::KIND_FILL) ||
                     (kind == dtim_core_pkg::KIND_HIT && is_store);
    end
    write_index     = decoded.index;
    write_line.lock = 1'b1;
    write_line.tag  = decoded.tag;
    write_line.data = merged;
  end

  assign rsp.ready = finish;
  assign rsp.rdata = is_store ? '0 : base; // Stores answer with zero.

endmodule

`default_nettype wire

/* rtl/dtim.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dtim_defines.svh"

module dtim (
  input  logic                    clock,
  input  logic                    reset,
  input  dtim_bus_pkg::dtim_req_t req,
  output dtim_bus_pkg::dtim_rsp_t rsp,
  output dtim_bus_pkg::mem_req_t  mem_req,
  input  dtim_bus_pkg::mem_rsp_t  mem_rsp
);

  logic [`DTIM_INDEX_BITS-1:0]  read_index;
  dtim_core_pkg::dtim_decoded_t decoded;
  dtim_core_pkg::dtim_line_t    line;
  logic                         finish;
  dtim_core_pkg::dtim_kind_t    kind;
  logic                         write_enable;
  logic [`DTIM_INDEX_BITS-1:0]  write_index;
  dtim_core_pkg::dtim_line_t    write_line;

  dtim_decode u_decode (
    .clock      (clock),
    .reset      (reset),
    .req        (req),
    .read_index (read_index),
    .decoded    (decoded)
  );

  dtim_store u_store (
    .clock        (clock),
    .read_index   (read_index),
    .line         (line),
    .write_enable (write_enable),
    .write_index  (write_index),
    .write_line   (write_line)
  );

  dtim_control u_control (
    .clock     (clock),
    .reset     (reset),
    .decoded   (decoded),
    .line      (line),
    .mem_req   (mem_req),
    .mem_ready (mem_rsp.ready),
    .finish    (finish),
    .kind      (kind)
  );

  dtim_respond u_respond (
    .decoded      (decoded),
    .line         (line),
    .mem_rdata    (mem_rsp.rdata),
    .finish       (finish),
    .kind         (kind),
    .rsp          (rsp),
    .write_enable (write_enable),
    .write_index  (write_index),
    .write_line   (write_line)
  );

endmodule

`default_nettype wire

/* sim/dtim_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module dtim_assert (
  input logic                    clock,
  input logic                    reset,
  input dtim_bus_pkg::dtim_req_t req,
  input dtim_bus_pkg::dtim_rsp_t rsp,
  input dtim_bus_pkg::mem_req_t  mem_req,
  input dtim_bus_pkg::mem_rsp_t  mem_rsp
);

  logic mem_pending;
  logic req_pending;
  int   failures = 0;

  always_ff @(posedge clock) begin
    if (!reset) begin
      mem_pending <= 1'b0;
      req_pending <= 1'b0;
    end else begin
      if (mem_req.valid) begin
        mem_pending <= 1'b1;
      end else if (mem_rsp.ready) begin
        mem_pending <= 1'b0;
      end
      if (req.valid) begin
        req_pending <= 1'b1;
      end else if (rsp.ready) begin
        req_pending <= 1'b0;
      end
    end
  end

  mem_valid_single: assert property (@(posedge clock) disable iff (!reset)
    mem_req.valid |=> !mem_req.valid)
    else begin
      failures++;
      $error("Memory valid lasted two cycles.");
    end

  mem_valid_waits: assert property (@(posedge clock) disable iff (!reset)
    mem_req.valid |-> !mem_pending)
    else begin
      failures++;
      $error("Memory valid rose again before the memory answered.");
    end

  ready_after_request: assert property (@(posedge clock) disable iff (!reset)
    rsp.ready |-> req_pending)
    else begin
      failures++;
      $error("Processor ready appeared without a request.");
    end

endmodule

bind dtim dtim_assert u_assert (
  .clock   (clock),
  .reset   (reset),
  .req     (req),
  .rsp     (rsp),
  .mem_req (mem_req),
  .mem_rsp (mem_rsp)
);

`default_nettype wire

/* sim/dtim_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dtim_tb;

  localparam logic [31:0] MODEL_PATTERN = 32'hA5A5_0000;

  logic                    clock;
  logic                    reset;
  dtim_bus_pkg::dtim_req_t req;
  dtim_bus_pkg::dtim_rsp_t rsp;
  dtim_bus_pkg::mem_req_t  mem_req;
  dtim_bus_pkg::mem_rsp_t  mem_rsp;

  logic [31:0] model_mem [logic [31:0]]; // Only words that were written are kept.

  string                     case_name [$];
  logic [31:0]               case_addr [$];
  logic [31:0]               case_wdata [$];
  logic [3:0]                case_wstrb [$];
  logic [31:0]               case_rdata [$];
  dtim_core_pkg::dtim_kind_t case_kind [$];
  bit                        loaded;

  dtim dut (
    .clock   (clock),
    .reset   (reset),
    .req     (req),
    .rsp     (rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_rsp(input string name, input dtim_bus_pkg::dtim_rsp_t expected,
                           input dtim_bus_pkg::dtim_rsp_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Mismatch in %s response: expected %h, actual %h",
                                  name, expected, actual));
    end
  endtask

  task automatic check_mem(input string name, input dtim_bus_pkg::mem_req_t expected,
                           input dtim_bus_pkg::mem_req_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Mismatch in %s memory request: expected %h, actual %h",
                                  name, expected, actual));
    end
  endtask

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (model_mem.exists(addr)) begin
      return model_mem[addr];
    end
    return addr ^ MODEL_PATTERN; // Untouched words follow the fill pattern.
  endfunction

  task automatic write_word(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb);
    logic [31:0] word;
    word = read_word(addr);
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) begin
        word[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    if (wstrb != 4'h0) begin
      model_mem[addr] = word;
    end
  endtask

  task automatic load_cases();
    int          fd;
    int          count;
    string       line;
    string       name;
    string       path;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic [31:0] rdata;
    fd = $fopen("sim/dtim_cases.txt", "r");
    if (fd == 0) begin
      stop_with_failure("The case file sim/dtim_cases.txt could not be opened.");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin
        count = $sscanf(line, "%s %h %h %h %h %s", name, addr, wdata, wstrb, rdata, path);
        if (count != 6) begin
          stop_with_failure($sformatf("A case line could not be read: %s", line));
        end
        case (path)
          "hit":    case_kind.push_back(dtim_core_pkg::KIND_HIT);
          "fill":   case_kind.push_back(dtim_core_pkg::KIND_FILL);
          "bypass": case_kind.push_back(dtim_core_pkg::KIND_BYPASS);
          default:  stop_with_failure($sformatf("Case %s names an unknown path.", name));
        endcase
        case_name.push_back(name);
        case_addr.push_back(addr);
        case_wdata.push_back(wdata);
        case_wstrb.push_back(wstrb);
        case_rdata.push_back(rdata);
      end
    end
    $fclose(fd);
  endtask

  task automatic run_case(input int i);
    dtim_bus_pkg::dtim_rsp_t expected_rsp;
    dtim_bus_pkg::mem_req_t  expected_mem;
    int                      cycles;
    int                      mem_count;
    expected_rsp.ready = 1'b1;
    expected_rsp.rdata = case_rdata[i];
    expected_mem.valid = 1'b1;
    expected_mem.addr  = {case_addr[i][31:2], 2'b00};
    expected_mem.wdata = (case_kind[i] == dtim_core_pkg::KIND_BYPASS) ? case_wdata[i] : '0;
    expected_mem.wstrb = (case_kind[i] == dtim_core_pkg::KIND_BYPASS) ? case_wstrb[i] : '0;
    @(negedge clock);
    req.valid = 1'b1;
    req.addr  = case_addr[i];
    req.wdata = case_wdata[i];
    req.wstrb = case_wstrb[i];
    @(posedge clock);
    @(negedge clock);
    req.valid = 1'b0;
    cycles    = 0;
    mem_count = 0;
    do begin
      @(posedge clock); // Outputs still hold the values of the cycle that ends here.
      cycles++;
      if (mem_req.valid) begin
        mem_count++;
        if (cycles != 1) begin
          stop_with_failure($sformatf(
            "Case %s raised a memory request %0d cycles after the request, not one.",
            case_name[i], cycles));
        end
        check_mem(case_name[i], expected_mem, mem_req);
      end
    end while (!rsp.ready);
    check_rsp(case_name[i], expected_rsp, rsp);
    if (case_kind[i] == dtim_core_pkg::KIND_HIT) begin
      if (cycles != 1 || mem_count != 0) begin
        stop_with_failure($sformatf(
          "Case %s was expected to hit, but took %0d cycles and %0d memory requests.",
          case_name[i], cycles, mem_count));
      end
    end else if (mem_count != 1) begin
      stop_with_failure($sformatf("Case %s made %0d memory requests instead of one.",
                                  case_name[i], mem_count));
    end else if (!mem_rsp.ready) begin
      stop_with_failure($sformatf("Case %s answered before the backing memory did.",
                                  case_name[i]));
    end
  endtask

  initial begin
    clock = 1'b0;
    forever begin
      #4 clock = ~clock;
    end
  end

  // Backing memory answers each strobe after 1 to 4 cycles.
  initial begin
    dtim_bus_pkg::mem_req_t seen;
    int                     delay;
    mem_rsp = '0;
    delay   = $urandom(9);
    forever begin
      @(posedge clock);
      if (reset && mem_req.valid) begin
        seen  = mem_req;
        delay = 1 + int'($urandom % 4);
        repeat (delay - 1) @(posedge clock);
        @(negedge clock);
        mem_rsp.ready = 1'b1;
        mem_rsp.rdata = read_word(seen.addr);
        write_word(seen.addr, seen.wdata, seen.wstrb);
        @(negedge clock);
        mem_rsp = '0;
      end
    end
  end

  initial begin
    wait (loaded);
    repeat (case_name.size() * 20) @(posedge clock);
    stop_with_failure($sformatf("Timeout after %0d cycles, the DUT stopped answering.",
                                case_name.size() * 20));
  end

  initial begin
    wait (dut.u_assert.failures != 0);
    stop_with_failure("A protocol assertion on the DUT ports failed.");
  end

  initial begin
    reset  = 1'b0;
    req    = '0;
    loaded = 1'b0;
    load_cases();
    loaded = 1'b1;
    repeat (5) @(negedge clock);
    reset = 1'b1;
    for (int i = 0; i < case_name.size(); i++) begin
      run_case(i);
    end
    @(negedge clock); // The assertions of the last edge have been evaluated by now.
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/dtim_cases.txt */
# Each line holds name, address, write data, strobes, expected read data and path.
# Numbers are hex, and the path is hit, fill or bypass.
fill_load       00001010 00000000 0 a5a51010 fill
hit_load        00001010 00000000 0 a5a51010 hit
store_hit       00001010 11223344 6 00000000 hit
load_merged     00001010 00000000 0 a5223310 hit
load_unaligned  00001013 00000000 0 a5223310 hit
store_fill      00001024 cafebabe 1 00000000 fill
load_filled     00001024 00000000 0 a5a510be hit
bypass_store    00004000 deadbeef c 00000000 bypass
bypass_load     00004000 00000000 0 dead4000 bypass
conflict_load   00001110 00000000 0 a5a51110 bypass
conflict_store  00001110 55667788 f 00000000 bypass
conflict_reload 00001110 00000000 0 55667788 bypass
locked_hit      00001010 00000000 0 a5223310 hit
below_window    00000800 00000000 0 a5a50800 bypass
fill_top        00002ffc 00000000 0 a5a52ffc fill
store_top       00002ffc 77000000 8 00000000 hit
load_top        00002ffc 00000000 0 77a52ffc hit
past_window     00003000 00000000 0 a5a53000 bypass

/* files.f */
+incdir+common
common/dtim_bus_pkg.sv
common/dtim_core_pkg.sv
rtl/dtim_decode.sv
rtl/dtim_store.sv
rtl/dtim_control.sv
rtl/dtim_respond.sv
rtl/dtim.sv
sim/dtim_assert.sv
sim/dtim_tb.sv

/* Makefile */
SOURCES := $(shell grep -v '^+' files.f) common/dtim_defines.svh

obj_dir/Vdtim_tb: files.f $(SOURCES)
	verilator --binary --timing --assert -f files.f --top-module dtim_tb

run: obj_dir/Vdtim_tb
	./obj_dir/Vdtim_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q '>>> FAIL' sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
